//--- logic/rssi_config.svh
`ifndef RSSI_CONFIG_SVH
`define RSSI_CONFIG_SVH

// sample stream
`define RSSI_SAMPLE_BW      16  // width of each of i and q
`define RSSI_N_USRS         4   // interleaved users on the stream
`define RSSI_USR_ID_BW      2   // user tag width

// measurement path
`define RSSI_ACC_BITS       40  // per-user power accumulator
`define RSSI_MULT_LATENCY   3   // squarer pipeline depth

// host register map, words 4..7 hold the per-user rssi
`define RSSI_ADDR_CTRL      0
`define RSSI_ADDR_PERIOD    1
`define RSSI_ADDR_STATUS    2
`define RSSI_ADDR_VALUE0    4

`endif

//--- logic/rssi_pkg.sv
`default_nettype none
`include "rssi_config.svh"

package rssi_pkg;

   // one signed i or q component of a baseband sample
   typedef logic signed [`RSSI_SAMPLE_BW-1:0] sample_t;

   // user tag carried alongside each sample
   typedef logic [`RSSI_USR_ID_BW-1:0] usr_id_t;

   // i^2 + q^2, one bit wider than a single square
   typedef logic [2*`RSSI_SAMPLE_BW:0] power_t;

   // running power sum of one user
   typedef logic [`RSSI_ACC_BITS-1:0] acc_t;

   // host register word, also the captured rssi word
   typedef logic [31:0] reg_word_t;

endpackage

`default_nettype wire

//--- logic/iq_square_mult.sv
`default_nettype none
`timescale 1ns/1ps
`include "rssi_config.svh"

module iq_square_mult (
   input  wire                             clk,
   input  wire                             clk_en,
   input  wire  [`RSSI_SAMPLE_BW-1:0]      a,
   output logic [2*`RSSI_SAMPLE_BW-1:0]    p
);

   localparam int W  = `RSSI_SAMPLE_BW;
   localparam int H  = W / 2;
   localparam int PW = 2 * W;

   logic [W-1:0] a_q;   // operand register
   logic [W-1:0] hh;    // hi * hi
   logic [W-1:0] hl;    // hi * lo, counted twice in the square
   logic [W-1:0] ll;    // lo * lo

   always_ff @(posedge clk) begin
      if (clk_en) begin
         a_q <= a;
      end
   end

   // split the square into half-width partial products
   always_ff @(posedge clk) begin
      if (clk_en) begin
         hh <= a_q[W-1:H] * a_q[W-1:H];
         hl <= a_q[W-1:H] * a_q[H-1:0];
         ll <= a_q[H-1:0] * a_q[H-1:0];
      end
   end

   // (h*2^H + l)^2 = hh*2^2H + 2*hl*2^H + ll
   always_ff @(posedge clk) begin
      if (clk_en) begin
         p <= {hh, {W{1'b0}}} + (PW'(hl) << (H + 1)) + PW'(ll);
      end
   end

   // result only comes out right when the last three cycles all advanced
   property p_square_latency;
      @(posedge clk)
         ($past(clk_en, 1) && $past(clk_en, 2) && $past(clk_en, 3))
         |-> (p == PW'($past(a, `RSSI_MULT_LATENCY)) * PW'($past(a, `RSSI_MULT_LATENCY)));
   endproperty

   a_square_latency : assert property (p_square_latency)
      else $error("squarer output is not the square of its operand");

endmodule

`default_nettype wire

//--- logic/iq_rssi_accum.sv
`default_nettype none
`timescale 1ns/1ps
`include "rssi_config.svh"

module iq_rssi_accum (
   input  wire                                      clk,
   input  wire                                      clk_en,
   input  wire                                      resetn,
   input  wire                                      tvalid,
   input  wire  [2*`RSSI_SAMPLE_BW-1:0]             tdata,
   input  wire  rssi_pkg::usr_id_t                  tusr,
   input  wire                                      capture_req,
   output logic                                     rssi_updated,
   output rssi_pkg::reg_word_t [`RSSI_N_USRS-1:0]   rssi_value
);

   localparam int W     = `RSSI_SAMPLE_BW;
   localparam int N     = `RSSI_N_USRS;
   localparam int ACC_W = `RSSI_ACC_BITS;
   localparam int LAT   = `RSSI_MULT_LATENCY + 2;   // input reg + squarer + sum reg
   localparam int RW    = $bits(rssi_pkg::reg_word_t);

   rssi_pkg::sample_t                in_i;
   rssi_pkg::sample_t                in_q;
   logic [W-1:0]                     i_mag;
   logic [W-1:0]                     q_mag;
   logic [2*W-1:0]                   i_sq;
   logic [2*W-1:0]                   q_sq;
   rssi_pkg::power_t                 iq_sum;
   logic [LAT-1:0]                   vld_dly;
   rssi_pkg::usr_id_t [LAT-1:0]      usr_dly;
   rssi_pkg::acc_t [N-1:0]           acc;
   logic                             cap_q;
   logic                             cap_load;
   logic                             cap_load_d;

   // |s| with the most negative code clipped to full scale
   function automatic logic [W-1:0] sat_abs(input rssi_pkg::sample_t s);
      if (s == {1'b1, {(W-1){1'b0}}}) begin
         return {1'b0, {(W-1){1'b1}}};
      end else if (s[W-1]) begin
         return W'(-s);
      end else begin
         return W'(s);
      end
   endfunction

   always_ff @(posedge clk) begin
      if (clk_en) begin
         in_i <= tdata[W-1:0];     // i in the lower half
         in_q <= tdata[2*W-1:W];   // q in the upper half
      end
   end

   assign i_mag = sat_abs(in_i);
   assign q_mag = sat_abs(in_q);

   iq_square_mult u_i_square (
      .clk    (clk),
      .clk_en (clk_en),
      .a      (i_mag),
      .p      (i_sq)
   );

   iq_square_mult u_q_square (
      .clk    (clk),
      .clk_en (clk_en),
      .a      (q_mag),
      .p      (q_sq)
   );

   always_ff @(posedge clk) begin
      if (clk_en) begin
         iq_sum <= rssi_pkg::power_t'(i_sq) + rssi_pkg::power_t'(q_sq);
      end
   end

   // valid and tag ride alongside the datapath
   always_ff @(posedge clk) begin
      if (!resetn) begin
         vld_dly <= '0;
         usr_dly <= '0;
      end else if (clk_en) begin
         vld_dly <= {vld_dly[LAT-2:0], tvalid};
         usr_dly <= {usr_dly[LAT-2:0], tusr};
      end
   end

   // rising edge of the request, one capture per pulse
   assign cap_load = capture_req & ~cap_q;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         cap_q        <= 1'b0;
         cap_load_d   <= 1'b0;
         rssi_updated <= 1'b0;
      end else if (clk_en) begin
         cap_q        <= capture_req;
         cap_load_d   <= cap_load;
         rssi_updated <= cap_load_d;   // words already stable by now
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         for (int u = 0; u < N; u++) begin
            acc[u]        <= '0;
            rssi_value[u] <= '0;
         end
      end else if (clk_en) begin
         for (int u = 0; u < N; u++) begin
            if (cap_load) begin
               rssi_value[u] <= acc[u][ACC_W-1 -: RW];   // drop the low 8 bits
               acc[u]        <= '0;                      // clear wins over a landing sample
            end else if (vld_dly[LAT-1] && (usr_dly[LAT-1] == rssi_pkg::usr_id_t'(u))) begin
               acc[u] <= acc[u] + rssi_pkg::acc_t'(iq_sum);
            end
         end
      end
   end

   // an update must trace back to a request from the register block,
   // judged when the cycle before the update also advanced
   property p_update_after_capture;
      @(posedge clk) disable iff (!resetn)
         ($rose(rssi_updated) && $past(clk_en, 2))
         |-> $past(capture_req, 2);
   endproperty

   a_update_after_capture : assert property (p_update_after_capture)
      else $error("rssi_updated raised without a preceding capture_req");

endmodule

`default_nettype wire

//--- logic/rssi_period_regs.sv
`default_nettype none
`timescale 1ns/1ps
`include "rssi_config.svh"

module rssi_period_regs (
   input  wire                                      clk,
   input  wire                                      clk_en,
   input  wire                                      resetn,
   input  wire                                      req,
   input  wire  [3:0]                               addr,
   input  wire                                      we,
   input  wire  rssi_pkg::reg_word_t                wdata,
   input  wire  rssi_pkg::reg_word_t [`RSSI_N_USRS-1:0] rssi_value,
   input  wire                                      rssi_updated,
   output logic                                     ack,
   output rssi_pkg::reg_word_t                      rdata,
   output logic                                     capture_req
);

   localparam logic [3:0] A_CTRL   = 4'(`RSSI_ADDR_CTRL);
   localparam logic [3:0] A_PERIOD = 4'(`RSSI_ADDR_PERIOD);
   localparam logic [3:0] A_STATUS = 4'(`RSSI_ADDR_STATUS);
   localparam int         VALUE0   = `RSSI_ADDR_VALUE0;
   localparam int         N        = `RSSI_N_USRS;

   logic                  req_q;
   logic                  access;
   logic                  manual_cap;
   logic                  rd_status;
   logic                  value_sel;
   rssi_pkg::usr_id_t     usr_idx;
   rssi_pkg::reg_word_t   rd_mux;
   logic                  timer_en;
   rssi_pkg::reg_word_t   period;
   rssi_pkg::reg_word_t   timer_cnt;
   logic                  timer_hit;
   logic                  status_updated;

   // access one cycle after req is seen, once per handshake
   assign access     = req & req_q & ~ack;
   assign manual_cap = access & we & (addr == A_CTRL) & wdata[1];
   assign rd_status  = access & ~we & (addr == A_STATUS);

   assign value_sel = (int'(addr) >= VALUE0) && (int'(addr) < VALUE0 + N);
   assign usr_idx   = rssi_pkg::usr_id_t'(int'(addr) - VALUE0);

   always_comb begin
      rd_mux = '0;
      if (value_sel) begin
         rd_mux = rssi_value[usr_idx];
      end else begin
         case (addr)
            A_CTRL:   rd_mux[0] = timer_en;         // manual bit reads zero
            A_PERIOD: rd_mux    = period;
            A_STATUS: rd_mux[0] = status_updated;
            default:  rd_mux    = '0;
         endcase
      end
   end

   // four-phase host port
   always_ff @(posedge clk) begin
      if (!resetn) begin
         req_q <= 1'b0;
         ack   <= 1'b0;
         rdata <= '0;
      end else if (clk_en) begin
         req_q <= req;
         if (access) begin
            ack   <= 1'b1;
            rdata <= rd_mux;
         end else if (ack && !req_q) begin
            ack <= 1'b0;   // one cycle after req dropped
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         timer_en <= 1'b0;
         period   <= '0;
      end else if (clk_en && access && we) begin
         case (addr)
            A_CTRL:   timer_en <= wdata[0];
            A_PERIOD: period   <= wdata;
            default:  ;   // status and rssi words are read only
         endcase
      end
   end

   // period of 0 holds the timer
   assign timer_hit = timer_en && (period != '0) && (timer_cnt >= period);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         timer_cnt   <= '0;
         capture_req <= 1'b0;
      end else if (clk_en) begin
         capture_req <= manual_cap | timer_hit;
         if (!timer_en || (period == '0) || timer_hit) begin
            timer_cnt <= '0;
         end else begin
            timer_cnt <= timer_cnt + 1'b1;
         end
      end
   end

   // sticky updated flag, a new update beats a clearing read
   always_ff @(posedge clk) begin
      if (!resetn) begin
         status_updated <= 1'b0;
      end else if (clk_en) begin
         if (rssi_updated) begin
            status_updated <= 1'b1;
         end else if (rd_status) begin
            status_updated <= 1'b0;
         end
      end
   end

   a_ack_needs_req : assert property (@(posedge clk) disable iff (!resetn)
      $rose(ack) |-> (req && $past(req) && $past(req, 2)))
      else $error("ack raised without a held host request");

   a_ack_after_req_drop : assert property (@(posedge clk) disable iff (!resetn)
      $fell(ack) |-> !req)
      else $error("ack dropped while the host still holds req");

endmodule

`default_nettype wire

//--- logic/iq_rssi_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "rssi_config.svh"

module iq_rssi_top (
   input  wire                              clk,
   input  wire                              clk_en,
   input  wire                              resetn,

   // interleaved sample stream, no back-pressure
   input  wire                              tvalid,
   input  wire  [2*`RSSI_SAMPLE_BW-1:0]     tdata,
   input  wire  rssi_pkg::usr_id_t          tusr,

   // host register port
   input  wire                              req,
   input  wire  [3:0]                       addr,
   input  wire                              we,
   input  wire  rssi_pkg::reg_word_t        wdata,
   output logic                             ack,
   output rssi_pkg::reg_word_t              rdata,

   output logic                             rssi_updated
);

   logic                                    capture_req;   // regs to engine
   rssi_pkg::reg_word_t [`RSSI_N_USRS-1:0]  rssi_value;    // engine to regs

   rssi_period_regs u_regs (
      .clk          (clk),
      .clk_en       (clk_en),
      .resetn       (resetn),
      .req          (req),
      .addr         (addr),
      .we           (we),
      .wdata        (wdata),
      .rssi_value   (rssi_value),
      .rssi_updated (rssi_updated),
      .ack          (ack),
      .rdata        (rdata),
      .capture_req  (capture_req)
   );

   iq_rssi_accum u_accum (
      .clk          (clk),
      .clk_en       (clk_en),
      .resetn       (resetn),
      .tvalid       (tvalid),
      .tdata        (tdata),
      .tusr         (tusr),
      .capture_req  (capture_req),
      .rssi_updated (rssi_updated),
      .rssi_value   (rssi_value)
   );

endmodule

`default_nettype wire

//--- testbench/rssi_checker.sv
`default_nettype none
`timescale 1ns/1ps

module rssi_checker (
   input  wire         clk,
   input  wire         resetn,
   input  wire         req,
   input  wire         ack,
   input  wire  [31:0] rdata,
   input  wire         rssi_updated,
   input  wire  [3:0]  addr,
   input  wire  [31:0] exp_word,
   input  wire         exp_check,
   input  wire         pulse_chk,   // strobe, compare pulse count then restart it
   input  wire  [31:0] pulse_lo,
   input  wire  [31:0] pulse_hi,
   output int          read_errs,
   output int          pulse_errs,
   output int          proto_errs
);

   logic ack_q;
   logic upd_q;
   int   pulses;

   always @(posedge clk) begin
      ack_q <= ack;
      upd_q <= rssi_updated;
      if (!resetn) begin
         read_errs  <= 0;
         pulse_errs <= 0;
         proto_errs <= 0;
         pulses     <= 0;
      end else begin
         // readback compare on the rising ack, rdata is loaded with it
         if (ack && !ack_q && exp_check && (rdata !== exp_word)) begin
            $display("ERROR: %0t read of address %0d returned %h, expected %h",
                     $time, addr, rdata, exp_word);
            read_errs <= read_errs + 1;
         end
         if (ack && !ack_q && !req) begin
            $display("ERROR: %0t ack rose with no request pending", $time);
            proto_errs <= proto_errs + 1;
         end
         if (!ack && ack_q && req) begin
            $display("ERROR: %0t ack dropped while the request was still held", $time);
            proto_errs <= proto_errs + 1;
         end
         // a pulse held over stalled cycles is still one update
         if (pulse_chk) begin
            if (pulses < int'(pulse_lo) || pulses > int'(pulse_hi)) begin
               $display("ERROR: %0t saw %0d rssi updates, expected %0d to %0d",
                        $time, pulses, pulse_lo, pulse_hi);
               pulse_errs <= pulse_errs + 1;
            end
            pulses <= (rssi_updated && !upd_q) ? 1 : 0;
         end else if (rssi_updated && !upd_q) begin
            pulses <= pulses + 1;
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_iq_rssi.sv
`default_nettype none
`timescale 1ns/1ps
`include "rssi_config.svh"

module tb_iq_rssi;

   logic        clk;
   logic        clk_en;
   logic        resetn;
   logic        tvalid;
   logic [31:0] tdata;
   logic [1:0]  tusr;
   logic        req;
   logic [3:0]  addr;
   logic        we;
   logic [31:0] wdata;
   wire         ack;
   wire  [31:0] rdata;
   wire         rssi_updated;

   logic [31:0] exp_word;
   logic        exp_check;
   logic        pulse_chk;
   logic [31:0] pulse_lo;
   logic [31:0] pulse_hi;
   int          read_errs;
   int          pulse_errs;
   int          proto_errs;

   int          seed;
   int          cycles;
   int          limit;
   logic        timer_on;
   int          en_cycles;

   iq_rssi_top i_dut (
      .clk          (clk),
      .clk_en       (clk_en),
      .resetn       (resetn),
      .tvalid       (tvalid),
      .tdata        (tdata),
      .tusr         (tusr),
      .req          (req),
      .addr         (addr),
      .we           (we),
      .wdata        (wdata),
      .ack          (ack),
      .rdata        (rdata),
      .rssi_updated (rssi_updated)
   );

   rssi_checker i_chk (
      .clk          (clk),
      .resetn       (resetn),
      .req          (req),
      .ack          (ack),
      .rdata        (rdata),
      .rssi_updated (rssi_updated),
      .addr         (addr),
      .exp_word     (exp_word),
      .exp_check    (exp_check),
      .pulse_chk    (pulse_chk),
      .pulse_lo     (pulse_lo),
      .pulse_hi     (pulse_hi),
      .read_errs    (read_errs),
      .pulse_errs   (pulse_errs),
      .proto_errs   (proto_errs)
   );

   always #2 clk = ~clk;

   // roughly one stalled cycle in five
   always @(posedge clk) begin
      clk_en <= ($random(seed) % 5) != 0;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (clk_en && timer_on) begin
         en_cycles <= en_cycles + 1;
      end
      if (limit > 0 && cycles > limit) begin
         $display("timeout: the test did not finish within %0d cycles", limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // return at the negedge before an enabled rising edge
   task automatic wait_enabled();
      @(negedge clk);
      while (!clk_en) begin
         @(negedge clk);
      end
   endtask

   task automatic send_sample(input int v, input int u, input int i, input int q);
      @(posedge clk);
      tvalid <= v[0];
      tusr   <= u[1:0];
      tdata  <= {q[15:0], i[15:0]};
      wait_enabled();
   endtask

   task automatic idle_cycles(input int n);
      @(posedge clk);
      tvalid <= 1'b0;
      repeat (n) wait_enabled();
   endtask

   task automatic host_access(input logic w, input logic [3:0] a, input logic [31:0] d,
                              input logic chk);
      while (ack) begin
         @(negedge clk);
      end
      @(posedge clk);
      tvalid    <= 1'b0;
      req       <= 1'b1;
      we        <= w;
      addr      <= a;
      wdata     <= d;
      exp_word  <= d;
      exp_check <= chk;
      @(negedge clk);
      while (!ack) begin
         @(negedge clk);
      end
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      while (ack) begin
         @(negedge clk);
      end
   endtask

   task automatic check_pulses(input int lo, input int hi);
      @(posedge clk);
      pulse_chk <= 1'b1;
      pulse_lo  <= lo;
      pulse_hi  <= hi;
      @(posedge clk);
      pulse_chk <= 1'b0;
   endtask

   initial begin
      int    fd;
      int    code;
      int    total;
      int    a0;
      int    a1;
      int    a2;
      int    a3;
      int    expect_n;
      int    vec_errs;
      logic [31:0] h0;
      logic [31:0] h1;
      byte   cmd;
      string line;

      clk       = 1'b0;
      clk_en    = 1'b0;
      resetn    = 1'b0;
      tvalid    = 1'b0;
      tdata     = '0;
      tusr      = '0;
      req       = 1'b0;
      addr      = '0;
      we        = 1'b0;
      wdata     = '0;
      exp_word  = '0;
      exp_check = 1'b0;
      pulse_chk = 1'b0;
      pulse_lo  = '0;
      pulse_hi  = '0;
      seed      = 32320;
      cycles    = 0;
      limit     = 0;
      timer_on  = 1'b0;
      en_cycles = 0;
      total     = 0;
      vec_errs  = 0;

      // first pass sizes the timeout
      fd = $fopen("testbench/rssi_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file testbench/rssi_vectors.txt");
         $display("Simulation failed");
         $finish;
      end
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 1 && line.getc(0) != "#") begin
            cmd = line.getc(0);
            if (cmd == "S") begin
               total += 2;
            end else if (cmd == "G") begin
               code = $sscanf(line, "%c %d", cmd, a0);
               total += a0;
            end else begin
               total += 8;
            end
         end
      end
      $fclose(fd);
      limit = 20 * total + 2000;

      repeat (4) @(posedge clk);
      resetn <= 1'b1;

      fd = $fopen("testbench/rssi_vectors.txt", "r");
      while (!$feof(fd)) begin
         code = $fgets(line, fd);
         if (code > 1 && line.getc(0) != "#") begin
            cmd = line.getc(0);
            case (cmd)
               "S": begin
                  code = $sscanf(line, "%c %d %d %d %d", cmd, a0, a1, a2, a3);
                  send_sample(a0, a1, a2, a3);
               end
               "G": begin
                  code = $sscanf(line, "%c %d", cmd, a0);
                  idle_cycles(a0);
               end
               "W": begin
                  code = $sscanf(line, "%c %h %h", cmd, h0, h1);
                  if (h0 == `RSSI_ADDR_CTRL && !h1[0]) begin
                     timer_on = 1'b0;
                  end
                  host_access(1'b1, h0[3:0], h1, 1'b0);
                  if (h0 == `RSSI_ADDR_CTRL && h1[0]) begin
                     en_cycles = 0;
                     timer_on  = 1'b1;
                  end
               end
               "R", "E": begin
                  code = $sscanf(line, "%c %h %h", cmd, h0, h1);
                  host_access(1'b0, h0[3:0], h1, 1'b1);
               end
               "U": begin
                  code = $sscanf(line, "%c %d %d", cmd, a0, a1);
                  check_pulses(a0, a1);
               end
               "T": begin
                  // one update per period+1 enabled cycles
                  code = $sscanf(line, "%c %d", cmd, a0);
                  expect_n = en_cycles / (a0 + 1);
                  check_pulses((expect_n > 0) ? expect_n - 1 : 0, expect_n + 1);
               end
               default: begin
                  $display("unknown vector command in line: %s", line);
                  vec_errs++;
               end
            endcase
         end
      end
      $fclose(fd);

      repeat (4) @(posedge clk);
      $display("errors: read %0d, update count %0d, protocol %0d, vector file %0d",
               read_errs, pulse_errs, proto_errs, vec_errs);
      if (read_errs + pulse_errs + proto_errs + vec_errs == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/rssi_vectors.txt
# S valid user i q (decimal) | G idle enabled cycles | W addr data, R/E addr expected (hex)
# U min max update pulses since last check | T period, timer pulse count check
U 0 0
R 0 0
R 1 0
R 2 0
E 4 0
E 5 0
E 6 0
E 7 0
S 1 0 1000 -2000
S 1 1 300 400
S 1 2 -32768 0
S 0 1 5000 5000
S 1 3 12345 6789
S 1 0 -1500 2500
S 1 1 32767 -32768
S 1 2 32767 0
S 1 3 0 0
G 10
W 0 2
G 10
U 1 1
R 2 1
R 2 0
E 4 cdfe
E 5 8001d0
E 6 7ffe00
E 7 bd4b5
S 1 0 -32768 -32768
S 1 2 100 100
S 1 3 -4096 0
G 10
W 0 2
G 10
U 1 1
E 4 7ffe00
E 5 0
E 6 4e
E 7 10000
W 0 2
G 10
U 1 1
E 4 0
E 5 0
E 6 0
E 7 0
R 2 1
R 2 0
W 1 9
R 1 9
W 0 1
R 0 1
G 200
W 0 0
G 10
T 9
R 2 1
R 2 0

//--- iq_rssi.f
+incdir+logic
logic/rssi_pkg.sv
logic/iq_square_mult.sv
logic/iq_rssi_accum.sv
logic/rssi_period_regs.sv
logic/iq_rssi_top.sv
testbench/rssi_checker.sv
testbench/tb_iq_rssi.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rssi testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module tb_iq_rssi -f iq_rssi.f

out=$(./obj_dir/Vtb_iq_rssi)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
else
   exit 1
fi
